//--- compile.f
+incdir+include
hdl/evcnt_pkg.sv
hdl/lb_decoder.sv
hdl/rst_cntrl.sv
hdl/event_channel.sv
hdl/lb_rd_merge.sv
hdl/evcnt_top.sv
tests/evcnt_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the event counter testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f --top-module evcnt_tb > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vevcnt_tb > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Testbench failed" "$SIM_LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation finished without failure"
exit 0

//--- tests/evcnt_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Event counter testbench: bus tasks, random events,
// register and counter reference model, response checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "evcnt_settings.svh"
`include "evcnt_regmap.svh"

module evcnt_tb;
  import evcnt_pkg::*;

  logic                     clk;
  logic                     rst_n;
  logic                     lb_wr_en;
  logic                     lb_rd_en;
  lb_addr_t                 lb_addr;
  lb_data_t                 lb_wr_data;
  logic                     lb_wr_valid;
  logic                     lb_rd_valid;
  lb_data_t                 lb_rd_data;
  logic [`EVCNT_NUM_CH-1:0] ev_in;
  logic [`EVCNT_NUM_CH-1:0] ch_flag;

  // Model of the register state, 1 = channel running
  logic [`EVCNT_NUM_CH-1:0] m_run;
  logic                     m_en  [`EVCNT_NUM_CH];
  cnt_t                     m_thr [`EVCNT_NUM_CH];
  cnt_t                     m_cnt [`EVCNT_NUM_CH];

  // Outstanding accesses, oldest at the front
  logic     pend_rd   [$];
  lb_data_t pend_data [$];
  lb_addr_t pend_addr [$];

  logic     ev_run;
  logic     ev_bit;
  int       err_cnt;
  int       chk_cnt;
  logic     mon_rd;
  lb_data_t mon_data;
  lb_addr_t mon_addr;

  evcnt_top UUT (
    .clk(clk), .rst_n(rst_n), .lb_wr_en(lb_wr_en), .lb_rd_en(lb_rd_en),
    .lb_addr(lb_addr), .lb_wr_data(lb_wr_data), .lb_wr_valid(lb_wr_valid),
    .lb_rd_valid(lb_rd_valid), .lb_rd_data(lb_rd_data), .ev_in(ev_in),
    .ch_flag(ch_flag)
  );

  // 4 ns clock
  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic lb_addr_t make_addr(int blk, int ofs);
    make_addr = {blk_idx_t'(blk), reg_ofs_t'(ofs)};
  endfunction

  // Expected read word from the register map rules
  function automatic lb_data_t expected_read(lb_addr_t addr);
    int       blk;
    int       ofs;
    int       ch;
    lb_data_t res;
    blk = int'(addr[`LB_ADDR_W-1 -: `LB_BLK_W]);
    ofs = int'(addr[`LB_OFS_W-1:0]);
    ch  = blk - `BLK_CH_BASE;
    res = `LB_DEFAULT_RD;
    if (blk == `BLK_RST_CNTRL)
    begin
      case (ofs)
        `RST_NUM_RESETS_OFS: res = lb_data_t'(`EVCNT_NUM_CH);
        `RST_REG_OFS:        res = lb_data_t'(m_run);
        default:             res = `LB_DEFAULT_RD;
      endcase
    end
    else if (ch >= 0 && ch < `EVCNT_NUM_CH)
    begin
      // Held channel answers zero everywhere
      if (!m_run[ch])
        res = '0;
      else
      begin
        case (ofs)
          `CH_CTRL_OFS:   res = lb_data_t'(m_en[ch]);
          `CH_THRESH_OFS: res = lb_data_t'(m_thr[ch]);
          `CH_COUNT_OFS:  res = lb_data_t'(m_cnt[ch]);
          default:        res = `LB_DEFAULT_RD;
        endcase
      end
    end
    expected_read = res;
  endfunction

  // Model update for a write
  function automatic void apply_write(lb_addr_t addr, lb_data_t data);
    int blk;
    int ofs;
    int ch;
    blk = int'(addr[`LB_ADDR_W-1 -: `LB_BLK_W]);
    ofs = int'(addr[`LB_OFS_W-1:0]);
    ch  = blk - `BLK_CH_BASE;
    if (blk == `BLK_RST_CNTRL && ofs == `RST_REG_OFS)
    begin
      m_run = data[`EVCNT_NUM_CH-1:0];
      for (int i = 0; i < `EVCNT_NUM_CH; i++)
      begin
        if (!m_run[i])
        begin
          m_en[i]  = 1'b0;
          m_thr[i] = '0;
          m_cnt[i] = '0;
        end
      end
    end
    else if (ch >= 0 && ch < `EVCNT_NUM_CH && m_run[ch])
    begin
      if (ofs == `CH_CTRL_OFS)
        m_en[ch] = data[0];
      else if (ofs == `CH_THRESH_OFS)
        m_thr[ch] = data[`CNT_W-1:0];
    end
  endfunction

  function automatic logic expected_flag(int ch);
    expected_flag = m_en[ch] && (m_cnt[ch] >= m_thr[ch]);
  endfunction

  task automatic check_value(string what, lb_data_t got, lb_data_t exp);
    chk_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("ERR at %0t ns: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic issue_write(lb_addr_t addr, lb_data_t data);
    @(posedge clk);
    lb_wr_en   <= 1'b1;
    lb_rd_en   <= 1'b0;
    lb_addr    <= addr;
    lb_wr_data <= data;
    apply_write(addr, data);
    pend_rd.push_back(1'b0);
    pend_data.push_back('0);
    pend_addr.push_back(addr);
  endtask

  // Expected word fixed at issue time, earlier writes already applied
  task automatic issue_read(lb_addr_t addr);
    @(posedge clk);
    lb_wr_en   <= 1'b0;
    lb_rd_en   <= 1'b1;
    lb_addr    <= addr;
    lb_wr_data <= '0;
    pend_rd.push_back(1'b1);
    pend_data.push_back(expected_read(addr));
    pend_addr.push_back(addr);
  endtask

  task automatic bus_idle;
    @(posedge clk);
    lb_wr_en <= 1'b0;
    lb_rd_en <= 1'b0;
  endtask

  // Until every issued access has seen its valid pulse
  task automatic wait_responses;
    int n;
    n = 0;
    while (pend_rd.size() != 0 && n < 40)
    begin
      @(posedge clk);
      n++;
    end
    if (pend_rd.size() != 0)
    begin
      $display("Timeout: %0d bus accesses got no valid pulse", pend_rd.size());
      $display("Testbench failed");
      $finish;
    end
  endtask

  task automatic bus_write(lb_addr_t addr, lb_data_t data);
    issue_write(addr, data);
    bus_idle();
    wait_responses();
  endtask

  task automatic read_all_counts;
    for (int i = 0; i < `EVCNT_NUM_CH; i++)
    begin
      issue_read(make_addr(`BLK_CH_BASE + i, `CH_COUNT_OFS));
    end
  endtask

  task automatic start_events;
    @(posedge clk);
    ev_run <= 1'b1;
  endtask

  // Events back to low, then sync and edge detect drain
  task automatic stop_events;
    @(posedge clk);
    ev_run <= 1'b0;
    repeat (6) @(posedge clk);
  endtask

  task automatic check_flags;
    @(negedge clk);
    for (int i = 0; i < `EVCNT_NUM_CH; i++)
    begin
      check_value($sformatf("ch_flag[%0d]", i), lb_data_t'(ch_flag[i]),
                  lb_data_t'(expected_flag(i)));
    end
  endtask

  // Random event levels, rising edges counted in the model
  always @(posedge clk)
  begin
    for (int i = 0; i < `EVCNT_NUM_CH; i++)
    begin
      ev_bit = ev_run && (($urandom() & 32'd1) == 32'd1);
      if (ev_bit && !ev_in[i] && m_run[i] && m_en[i] && m_cnt[i] != '1)
        m_cnt[i] = m_cnt[i] + cnt_t'(1);
      ev_in[i] <= ev_bit;
    end
  end

  // Valid pulses against the outstanding queue, in issue order
  always @(negedge clk)
  begin
    if (rst_n && (lb_wr_valid || lb_rd_valid))
    begin
      if (lb_wr_valid && lb_rd_valid)
      begin
        err_cnt++;
        $display("Write and read valid were high together at %0t ns", $time);
      end
      else if (pend_rd.size() == 0)
      begin
        err_cnt++;
        $display("Valid pulse with no access outstanding at %0t ns", $time);
      end
      else
      begin
        mon_rd   = pend_rd.pop_front();
        mon_data = pend_data.pop_front();
        mon_addr = pend_addr.pop_front();
        check_value($sformatf("read flag of access to %h", mon_addr),
                    lb_data_t'(lb_rd_valid), lb_data_t'(mon_rd));
        if (mon_rd)
          check_value($sformatf("read data of %h", mon_addr), lb_rd_data, mon_data);
      end
    end
  end

  initial
  begin
    rst_n      = 1'b0;
    lb_wr_en   = 1'b0;
    lb_rd_en   = 1'b0;
    lb_addr    = '0;
    lb_wr_data = '0;
    ev_in      = '0;
    ev_run     = 1'b0;
    err_cnt    = 0;
    chk_cnt    = 0;
    m_run      = '0;
    for (int i = 0; i < `EVCNT_NUM_CH; i++)
    begin
      m_en[i]  = 1'b0;
      m_thr[i] = '0;
      m_cnt[i] = '0;
    end
    void'($urandom(9));
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);

    // All held after reset, counts stay zero under toggling events
    start_events();
    issue_read(make_addr(`BLK_RST_CNTRL, `RST_NUM_RESETS_OFS));
    issue_read(make_addr(`BLK_RST_CNTRL, `RST_REG_OFS));
    read_all_counts();
    bus_idle();
    wait_responses();
    repeat (30) @(posedge clk);
    read_all_counts();
    bus_idle();
    wait_responses();
    stop_events();
    check_flags();

    // Reset vector keeps only the low bits
    bus_write(make_addr(`BLK_RST_CNTRL, `RST_REG_OFS), 32'ha5a5_a5f5);
    issue_read(make_addr(`BLK_RST_CNTRL, `RST_REG_OFS));
    issue_write(make_addr(`BLK_RST_CNTRL, `RST_REG_OFS), 32'h0000_0007);
    issue_read(make_addr(`BLK_RST_CNTRL, `RST_REG_OFS));
    // Channel 3 stays held and drops writes
    issue_write(make_addr(`BLK_CH_BASE + 3, `CH_CTRL_OFS), 32'h1);
    issue_write(make_addr(`BLK_CH_BASE + 3, `CH_THRESH_OFS), 32'h2);
    issue_read(make_addr(`BLK_CH_BASE + 3, `CH_CTRL_OFS));
    issue_read(make_addr(`BLK_CH_BASE + 3, `CH_THRESH_OFS));
    bus_idle();
    wait_responses();

    // Ch0 and ch1 enabled, ch2 released but idle
    issue_write(make_addr(`BLK_CH_BASE + 0, `CH_THRESH_OFS), 32'h4);
    issue_write(make_addr(`BLK_CH_BASE + 1, `CH_THRESH_OFS), 32'h400);
    issue_write(make_addr(`BLK_CH_BASE + 2, `CH_THRESH_OFS), 32'h1);
    issue_write(make_addr(`BLK_CH_BASE + 0, `CH_CTRL_OFS), 32'h1);
    issue_write(make_addr(`BLK_CH_BASE + 1, `CH_CTRL_OFS), 32'h1);
    for (int i = 0; i < `EVCNT_NUM_CH; i++)
    begin
      issue_read(make_addr(`BLK_CH_BASE + i, `CH_CTRL_OFS));
      issue_read(make_addr(`BLK_CH_BASE + i, `CH_THRESH_OFS));
    end
    bus_idle();
    wait_responses();
    start_events();
    repeat (80) @(posedge clk);
    stop_events();
    read_all_counts();
    bus_idle();
    wait_responses();
    check_flags();

    // Ch1 threshold dropped under its count
    bus_write(make_addr(`BLK_CH_BASE + 1, `CH_THRESH_OFS), 32'h2);
    check_flags();
    start_events();
    repeat (60) @(posedge clk);
    stop_events();
    read_all_counts();
    bus_idle();
    wait_responses();
    check_flags();

    // Back to back mix with unmapped blocks and unknown offsets
    issue_write(make_addr(`BLK_CH_BASE + 0, `CH_THRESH_OFS), 32'h9);
    issue_read(make_addr(`BLK_CH_BASE + 0, `CH_THRESH_OFS));
    issue_read(make_addr(`BLK_CH_BASE + `EVCNT_NUM_CH, 0));
    issue_write(make_addr(15, `RST_REG_OFS), 32'h0);
    issue_read(make_addr(15, 8'h33));
    issue_read(make_addr(`BLK_RST_CNTRL, 2));
    issue_read(make_addr(`BLK_RST_CNTRL, 8'hff));
    issue_read(make_addr(`BLK_CH_BASE + 0, 3));
    issue_read(make_addr(`BLK_CH_BASE + 1, 8'h80));
    issue_read(make_addr(`BLK_CH_BASE + 3, 5));
    issue_read(make_addr(`BLK_RST_CNTRL, `RST_REG_OFS));
    bus_idle();
    wait_responses();
    check_flags();

    // Soft reset pulse on ch0 clears enable, threshold and count
    bus_write(make_addr(`BLK_RST_CNTRL, `RST_REG_OFS), 32'h6);
    check_flags();
    bus_write(make_addr(`BLK_RST_CNTRL, `RST_REG_OFS), 32'h7);
    issue_read(make_addr(`BLK_CH_BASE + 0, `CH_CTRL_OFS));
    issue_read(make_addr(`BLK_CH_BASE + 0, `CH_THRESH_OFS));
    issue_read(make_addr(`BLK_CH_BASE + 0, `CH_COUNT_OFS));
    bus_idle();
    wait_responses();
    check_flags();

    $display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

//--- hdl/evcnt_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Event counter top: decoder, reset bank, channels and merge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "evcnt_settings.svh"

module evcnt_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     lb_wr_en,
  input  logic                     lb_rd_en,
  input  evcnt_pkg::lb_addr_t      lb_addr,
  input  evcnt_pkg::lb_data_t      lb_wr_data,
  output logic                     lb_wr_valid,
  output logic                     lb_rd_valid,
  output evcnt_pkg::lb_data_t      lb_rd_data,
  input  logic [`EVCNT_NUM_CH-1:0] ev_in,
  output logic [`EVCNT_NUM_CH-1:0] ch_flag
);
  import evcnt_pkg::*;

  // Decoder to targets
  reg_ofs_t                 reg_ofs;
  lb_data_t                 wr_data;
  logic                     rc_wr_sel;
  logic                     rc_rd_sel;
  logic                     miss_wr;
  logic                     miss_rd;
  logic [`EVCNT_NUM_CH-1:0] ch_wr_sel;
  logic [`EVCNT_NUM_CH-1:0] ch_rd_sel;

  // Targets to merge
  logic                                rc_wr_ack;
  logic                                rc_rd_ack;
  lb_data_t                            rc_rd_data;
  logic [`EVCNT_NUM_CH-1:0]            ch_wr_ack;
  logic [`EVCNT_NUM_CH-1:0]            ch_rd_ack;
  logic [`EVCNT_NUM_CH*`LB_DATA_W-1:0] ch_rd_data;

  logic [`EVCNT_NUM_CH-1:0] cntrl_rst_n;

  lb_decoder u_decoder (
    .clk(clk), .rst_n(rst_n), .lb_wr_en(lb_wr_en), .lb_rd_en(lb_rd_en),
    .lb_addr(lb_addr), .lb_wr_data(lb_wr_data), .reg_ofs(reg_ofs),
    .wr_data(wr_data), .rc_wr_sel(rc_wr_sel), .rc_rd_sel(rc_rd_sel),
    .miss_wr(miss_wr), .miss_rd(miss_rd), .ch_wr_sel(ch_wr_sel),
    .ch_rd_sel(ch_rd_sel)
  );

  rst_cntrl u_rst_cntrl (
    .clk(clk), .rst_n(rst_n), .wr_sel(rc_wr_sel), .rd_sel(rc_rd_sel),
    .reg_ofs(reg_ofs), .wr_data(wr_data), .wr_ack(rc_wr_ack),
    .rd_ack(rc_rd_ack), .rd_data(rc_rd_data), .cntrl_rst_n(cntrl_rst_n)
  );

  // One channel per reset bit
  for (genvar i = 0; i < `EVCNT_NUM_CH; i++)
  begin : g_ch
    event_channel u_ch (
      .clk(clk), .rst_n(rst_n), .soft_rst_n(cntrl_rst_n[i]), .ev_in(ev_in[i]),
      .wr_sel(ch_wr_sel[i]), .rd_sel(ch_rd_sel[i]), .reg_ofs(reg_ofs),
      .wr_data(wr_data), .wr_ack(ch_wr_ack[i]), .rd_ack(ch_rd_ack[i]),
      .rd_data(ch_rd_data[i*`LB_DATA_W +: `LB_DATA_W]), .ch_flag(ch_flag[i])
    );
  end

  lb_rd_merge u_merge (
    .clk(clk), .rst_n(rst_n), .rc_wr_ack(rc_wr_ack), .rc_rd_ack(rc_rd_ack),
    .miss_wr(miss_wr), .miss_rd(miss_rd), .rc_rd_data(rc_rd_data),
    .ch_wr_ack(ch_wr_ack), .ch_rd_ack(ch_rd_ack), .ch_rd_data(ch_rd_data),
    .lb_wr_valid(lb_wr_valid), .lb_rd_valid(lb_rd_valid), .lb_rd_data(lb_rd_data)
  );

endmodule

//--- hdl/lb_rd_merge.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Response merge onto the registered bus valids and read data
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "evcnt_settings.svh"

module lb_rd_merge (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 rc_wr_ack,
  input  logic                                 rc_rd_ack,
  input  logic                                 miss_wr,
  input  logic                                 miss_rd,
  input  evcnt_pkg::lb_data_t                  rc_rd_data,
  input  logic [`EVCNT_NUM_CH-1:0]             ch_wr_ack,
  input  logic [`EVCNT_NUM_CH-1:0]             ch_rd_ack,
  input  logic [`EVCNT_NUM_CH*`LB_DATA_W-1:0]  ch_rd_data,
  output logic                                 lb_wr_valid,
  output logic                                 lb_rd_valid,
  output evcnt_pkg::lb_data_t                  lb_rd_data
);
  import evcnt_pkg::*;

  // Miss strobes skip the target stage, delayed here to line up
  logic     miss_wr_q;
  logic     miss_rd_q;
  lb_data_t or_data;

  // Targets drive zero when idle
  always_comb
  begin
    or_data = rc_rd_data | (miss_rd_q ? `LB_DEFAULT_RD : '0);
    for (int i = 0; i < `EVCNT_NUM_CH; i++)
    begin
      or_data = or_data | ch_rd_data[i*`LB_DATA_W +: `LB_DATA_W];
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      miss_wr_q   <= 1'b0;
      miss_rd_q   <= 1'b0;
      lb_wr_valid <= 1'b0;
      lb_rd_valid <= 1'b0;
    end
    else
    begin
      miss_wr_q   <= miss_wr;
      miss_rd_q   <= miss_rd;
      lb_wr_valid <= rc_wr_ack || (|ch_wr_ack) || miss_wr_q;
      lb_rd_valid <= rc_rd_ack || (|ch_rd_ack) || miss_rd_q;
    end
  end

  always_ff @(posedge clk)
  begin
    lb_rd_data <= or_data;
  end

  // OR merge is only valid with a single responder
  a_one_rd_ack: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({rc_rd_ack, ch_rd_ack, miss_rd_q}))
    else $error("lb_rd_merge: more than one read response");

endmodule

//--- hdl/event_channel.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Event counter channel with sync, edge detect and threshold
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "evcnt_settings.svh"
`include "evcnt_regmap.svh"

module event_channel (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                soft_rst_n,
  input  logic                ev_in,
  input  logic                wr_sel,
  input  logic                rd_sel,
  input  evcnt_pkg::reg_ofs_t reg_ofs,
  input  evcnt_pkg::lb_data_t wr_data,
  output logic                wr_ack,
  output logic                rd_ack,
  output evcnt_pkg::lb_data_t rd_data,
  output logic                ch_flag
);
  import evcnt_pkg::*;

  logic     ev_meta;
  logic     ev_sync;
  logic     ev_prev;
  logic     ev_rise;
  logic     enable;
  cnt_t     threshold;
  cnt_t     count;
  lb_data_t rd_word;

  // Two-stage synchronizer plus a delay tap for edge detection
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ev_meta <= 1'b0;
      ev_sync <= 1'b0;
      ev_prev <= 1'b0;
    end
    else
    begin
      ev_meta <= ev_in;
      ev_sync <= ev_meta;
      ev_prev <= ev_sync;
    end
  end

  assign ev_rise = ev_sync && !ev_prev;

  // Soft reset wins over bus writes and counting
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      enable    <= 1'b0;
      threshold <= '0;
      count     <= '0;
    end
    else if (!soft_rst_n)
    begin
      enable    <= 1'b0;
      threshold <= '0;
      count     <= '0;
    end
    else
    begin
      if (wr_sel && (reg_ofs == reg_ofs_t'(`CH_CTRL_OFS)))
      begin
        enable <= wr_data[0];
      end
      if (wr_sel && (reg_ofs == reg_ofs_t'(`CH_THRESH_OFS)))
      begin
        threshold <= wr_data[`CNT_W-1:0];
      end
      // Saturate at all ones
      if (enable && ev_rise && (count != '1))
      begin
        count <= count + 1'b1;
      end
    end
  end

  // Held channels read as zero at every offset
  always_comb
  begin
    if (!soft_rst_n)
    begin
      rd_word = '0;
    end
    else
    begin
      case (reg_ofs)
        reg_ofs_t'(`CH_CTRL_OFS):   rd_word = lb_data_t'(enable);
        reg_ofs_t'(`CH_THRESH_OFS): rd_word = lb_data_t'(threshold);
        reg_ofs_t'(`CH_COUNT_OFS):  rd_word = lb_data_t'(count);
        default:                    rd_word = `LB_DEFAULT_RD;
      endcase
    end
  end

  // Bus response, acks even while held in soft reset
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ack  <= 1'b0;
      rd_ack  <= 1'b0;
      rd_data <= '0;
    end
    else
    begin
      wr_ack  <= wr_sel;
      rd_ack  <= rd_sel;
      rd_data <= rd_sel ? rd_word : '0;
    end
  end

  assign ch_flag = enable && (count >= threshold);

  // Count only moves up unless the previous cycle held a soft reset
  a_count_mono: assert property (@(posedge clk) disable iff (!rst_n)
    $past(soft_rst_n) |-> (count >= $past(count)))
    else $error("event_channel: count decreased without soft reset");

endmodule

//--- hdl/rst_cntrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Software reset register bank with channel count readback
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "evcnt_settings.svh"
`include "evcnt_regmap.svh"

module rst_cntrl (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     wr_sel,
  input  logic                     rd_sel,
  input  evcnt_pkg::reg_ofs_t      reg_ofs,
  input  evcnt_pkg::lb_data_t      wr_data,
  output logic                     wr_ack,
  output logic                     rd_ack,
  output evcnt_pkg::lb_data_t      rd_data,
  output logic [`EVCNT_NUM_CH-1:0] cntrl_rst_n
);
  import evcnt_pkg::*;

  lb_data_t rd_word;

  // Readback mux
  always_comb
  begin
    case (reg_ofs)
      reg_ofs_t'(`RST_NUM_RESETS_OFS): rd_word = lb_data_t'(`EVCNT_NUM_CH);
      reg_ofs_t'(`RST_REG_OFS):        rd_word = lb_data_t'(cntrl_rst_n);
      default:                         rd_word = `LB_DEFAULT_RD;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      // Every channel held in reset until software releases it
      cntrl_rst_n <= '0;
      wr_ack      <= 1'b0;
      rd_ack      <= 1'b0;
      rd_data     <= '0;
    end
    else
    begin
      // 1 = channel running
      if (wr_sel && (reg_ofs == reg_ofs_t'(`RST_REG_OFS)))
      begin
        cntrl_rst_n <= wr_data[`EVCNT_NUM_CH-1:0];
      end
      wr_ack  <= wr_sel;
      rd_ack  <= rd_sel;
      // Zero between reads so the merge can OR
      rd_data <= rd_sel ? rd_word : '0;
    end
  end

endmodule

//--- hdl/lb_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Local bus address decoder with registered target selects
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "evcnt_settings.svh"
`include "evcnt_regmap.svh"

module lb_decoder (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     lb_wr_en,
  input  logic                     lb_rd_en,
  input  evcnt_pkg::lb_addr_t      lb_addr,
  input  evcnt_pkg::lb_data_t      lb_wr_data,
  output evcnt_pkg::reg_ofs_t      reg_ofs,
  output evcnt_pkg::lb_data_t      wr_data,
  output logic                     rc_wr_sel,
  output logic                     rc_rd_sel,
  output logic                     miss_wr,
  output logic                     miss_rd,
  output logic [`EVCNT_NUM_CH-1:0] ch_wr_sel,
  output logic [`EVCNT_NUM_CH-1:0] ch_rd_sel
);
  import evcnt_pkg::*;

  blk_idx_t                 blk;
  logic                     rc_hit;
  logic [`EVCNT_NUM_CH-1:0] ch_hit;
  logic                     miss;

  // Block index from the top bits
  assign blk = lb_addr[`LB_ADDR_W-1 -: `LB_BLK_W];

  // One-hot block match, anything left over is a miss
  always_comb
  begin
    rc_hit = (blk == blk_idx_t'(`BLK_RST_CNTRL));
    for (int i = 0; i < `EVCNT_NUM_CH; i++)
    begin
      ch_hit[i] = (blk == blk_idx_t'(`BLK_CH_BASE + i));
    end
    miss = !rc_hit && !(|ch_hit);
  end

  // Select strobes, one cycle after the bus strobe
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rc_wr_sel <= 1'b0;
      rc_rd_sel <= 1'b0;
      miss_wr   <= 1'b0;
      miss_rd   <= 1'b0;
      ch_wr_sel <= '0;
      ch_rd_sel <= '0;
    end
    else
    begin
      rc_wr_sel <= lb_wr_en && rc_hit;
      rc_rd_sel <= lb_rd_en && rc_hit;
      miss_wr   <= lb_wr_en && miss;
      miss_rd   <= lb_rd_en && miss;
      ch_wr_sel <= {`EVCNT_NUM_CH{lb_wr_en}} & ch_hit;
      ch_rd_sel <= {`EVCNT_NUM_CH{lb_rd_en}} & ch_hit;
    end
  end

  // Offset and data shared by all targets, held between accesses
  always_ff @(posedge clk)
  begin
    if (lb_wr_en || lb_rd_en)
    begin
      reg_ofs <= lb_addr[`LB_OFS_W-1:0];
      wr_data <= lb_wr_data;
    end
  end

  // Only one target, or the miss path, sees any given access
  a_one_target: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({rc_wr_sel, rc_rd_sel, miss_wr, miss_rd, ch_wr_sel, ch_rd_sel}))
    else $error("lb_decoder: more than one select strobe high");

endmodule

//--- hdl/evcnt_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared vector types for bus, register offsets and counts
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "evcnt_settings.svh"

package evcnt_pkg;

  // Full local bus address
  typedef logic [`LB_ADDR_W-1:0] lb_addr_t;

  // Bus data word, both directions
  typedef logic [`LB_DATA_W-1:0] lb_data_t;

  // Upper address field, picks the target block
  typedef logic [`LB_BLK_W-1:0]  blk_idx_t;

  // Lower address field, register inside a block
  typedef logic [`LB_OFS_W-1:0]  reg_ofs_t;

  // Event count and threshold
  typedef logic [`CNT_W-1:0]     cnt_t;

endpackage

//--- include/evcnt_settings.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Build settings for the event counter block: channel count,
// local bus widths, address split and default read pattern
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef EVCNT_SETTINGS_SVH
`define EVCNT_SETTINGS_SVH

// Counter channels, also the width of the soft reset vector
`define EVCNT_NUM_CH  4

// Local bus widths
`define LB_ADDR_W     12
`define LB_DATA_W     32

// Address split, block index on top and register offset below
`define LB_BLK_W      4
`define LB_OFS_W      8

// Returned for unmapped blocks and unknown offsets
`define LB_DEFAULT_RD 32'hdeadbabe

// Event counter width
`define CNT_W         16

`endif

//--- include/evcnt_regmap.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register map: block indices and register offsets
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef EVCNT_REGMAP_SVH
`define EVCNT_REGMAP_SVH

// Block indices, channel i sits at block BLK_CH_BASE+i
`define BLK_RST_CNTRL       0
`define BLK_CH_BASE         1

// Reset controller offsets
`define RST_NUM_RESETS_OFS  0
`define RST_REG_OFS         1

// Channel offsets
`define CH_CTRL_OFS         0
`define CH_THRESH_OFS       1
`define CH_COUNT_OFS        2

`endif
